// File: src/tdc_macros.svh
`default_nettype none

`ifndef TDC_MACROS_SVH
`define TDC_MACROS_SVH

// system clocks per SPI half period, 3 gives about 8 MHz sck at 50 MHz
`define TDC_SPI_CLK_DIV 3

`define FIFO_ADDR_W 3       // 8 records
`define REC_SYNC 8'hA5      // leads every record toward the host

// cycles to wait for intb before the record is marked as timed out
`define INTB_TIMEOUT 2000

`define REF_CLK_DIV 4       // ref clock half period in system clocks

`endif

`default_nettype wire

// File: src/host_pkg.sv
`default_nettype none

package host_pkg;

  // one host byte, read as a control op or a burst setting
  // bit 7 picks the view
  typedef union packed {
    struct packed {
      logic       is_cfg;   // 0 here
      logic [2:0] op;
      logic [3:0] rsvd;
    } ctrl;
    struct packed {
      logic       is_cfg;   // 1 here
      logic [6:0] count;    // burst length, 0 means 1
    } cfg;
  } host_cmd_u;

  localparam logic [2:0] OP_ENABLE     = 3'd1;
  localparam logic [2:0] OP_DISABLE    = 3'd2;
  localparam logic [2:0] OP_PLAY       = 3'd3;
  localparam logic [2:0] OP_PAUSE      = 3'd4;
  localparam logic [2:0] OP_SOFT_RESET = 3'd5;   // codes 0, 6, 7 are ignored

endpackage

`default_nettype wire

// File: src/tdc_pkg.sv
`default_nettype none

package tdc_pkg;

  // time result registers of the TDC chip
  localparam logic [5:0] TDC_REG_TIME1 = 6'h10;
  localparam logic [5:0] TDC_REG_TIME2 = 6'h11;

  // read frame is one command byte then three data bytes, msb first
  localparam int TDC_FRAME_BYTES = 4;

  localparam int TDC_TIME_W = 24;

  // stored in both fields when intb never falls
  localparam logic [TDC_TIME_W-1:0] TDC_TIME_TIMEOUT = {TDC_TIME_W{1'b1}};

endpackage

`default_nettype wire

// File: src/host_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module host_cmd_decode (
  input  wire        clk,
  input  wire        rst,
  input  wire  [7:0] rx_data,
  input  wire        new_rx_data,
  output logic       tdc_enable,
  output logic       play,
  output logic       pause,
  output logic       soft_reset,
  output logic [6:0] burst_len
);
  import host_pkg::*;

  host_cmd_u cmd;

  assign cmd = host_cmd_u'(rx_data);

  always_ff @(posedge clk) begin
    // pulses last one cycle
    play       <= 1'b0;
    pause      <= 1'b0;
    soft_reset <= 1'b0;
    if (rst) begin
      tdc_enable <= 1'b0;
      burst_len  <= 7'd1;
    end else if (new_rx_data) begin
      if (cmd.cfg.is_cfg) begin
        burst_len <= (cmd.cfg.count == 7'd0) ? 7'd1 : cmd.cfg.count;
      end else begin
        case (cmd.ctrl.op)
          OP_ENABLE:  tdc_enable <= 1'b1;
          OP_DISABLE: tdc_enable <= 1'b0;
          OP_PLAY:    play <= 1'b1;
          OP_PAUSE:   pause <= 1'b1;
          OP_SOFT_RESET: begin
            soft_reset <= 1'b1;
            burst_len  <= 7'd1;   // enable level is kept
          end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: src/tdc_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_spi_master #(
  parameter int CLK_DIV = 3
) (
  input  wire        clk,
  input  wire        rst,
  input  wire        start,
  input  wire        last,
  input  wire  [7:0] data_in,
  output logic [7:0] data_out,
  output logic       busy,
  output logic       new_data,
  output logic       sck,
  output logic       mosi,
  input  wire        miso,
  output logic       cs_n
);
  localparam int DIV_W = $clog2(CLK_DIV + 1);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_LEAD = 2'd1;  // one cycle of mosi setup
  localparam logic [1:0] ST_XFER = 2'd2;

  logic [1:0]       state;
  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       half_cnt;   // 16 sck half periods per byte
  logic [7:0]       shreg;
  logic             rx_bit;
  logic             last_q;

  assign busy     = (state != ST_IDLE);
  assign data_out = shreg;
  assign mosi     = shreg[7];

  always_ff @(posedge clk) begin
    new_data <= 1'b0;
    if (rst) begin
      state    <= ST_IDLE;
      sck      <= 1'b0;
      cs_n     <= 1'b1;
      div_cnt  <= '0;
      half_cnt <= '0;
      last_q   <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: if (start) begin
          shreg  <= data_in;
          last_q <= last;
          cs_n   <= 1'b0;     // no change if the frame is already open
          state  <= ST_LEAD;
        end
        ST_LEAD: begin
          div_cnt  <= '0;
          half_cnt <= '0;
          state    <= ST_XFER;
        end
        ST_XFER: begin
          if (div_cnt == DIV_W'(CLK_DIV - 1)) begin
            div_cnt  <= '0;
            sck      <= ~sck;
            half_cnt <= half_cnt + 4'd1;
            if (!sck) rx_bit <= miso;                // rising edge, sample
            else shreg <= {shreg[6:0], rx_bit};      // falling edge, shift
            if (half_cnt == 4'd15) begin
              new_data <= 1'b1;
              state    <= ST_IDLE;
              if (last_q) cs_n <= 1'b1;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/tdc_measure_ctrl.sv
`timescale 1ns/1ps
`include "tdc_macros.svh"
`default_nettype none

module tdc_measure_ctrl (
  input  wire         clk,
  input  wire         rst,
  input  wire         tdc_enable,
  input  wire         play,
  input  wire         pause,
  input  wire         soft_reset,
  input  wire   [6:0] burst_len,
  input  wire         fifo_full,
  output logic        start_signal,
  input  wire         tdc_intb,
  output logic        ref_clock,
  output logic        spi_start,
  output logic        spi_last,
  output logic  [7:0] spi_data_in,
  input  wire   [7:0] spi_data_out,
  input  wire         spi_busy,
  input  wire         spi_new_data,
  output logic        fifo_wr,
  output logic [2*tdc_pkg::TDC_TIME_W-1:0] rec_data
);
  import tdc_pkg::*;

  localparam int TMR_W = $clog2(`INTB_TIMEOUT);
  localparam int REF_W = $clog2(`REF_CLK_DIV + 1);
  localparam logic [1:0] LAST_BYTE = 2'(TDC_FRAME_BYTES - 1);

  localparam logic [2:0] S_IDLE       = 3'd0;
  localparam logic [2:0] S_WAIT_INT   = 3'd1;
  localparam logic [2:0] S_SPI_SEND   = 3'd2;
  localparam logic [2:0] S_SPI_WAIT   = 3'd3;
  localparam logic [2:0] S_CLOSE      = 3'd4;  // end an open SPI frame after abort
  localparam logic [2:0] S_CLOSE_WAIT = 3'd5;

  logic [2:0]       state;
  logic [6:0]       remaining;
  logic [TMR_W-1:0] timer;
  logic [1:0]       byte_cnt;
  logic             reg_sel;   // 0 TIME1, 1 TIME2
  logic             cs_open;   // cs_n stays low after the current byte
  logic [REF_W-1:0] ref_cnt;
  logic             abort;
  logic             meas_busy;

  assign abort     = soft_reset || !tdc_enable;
  assign meas_busy = state inside {S_WAIT_INT, S_SPI_SEND, S_SPI_WAIT};

  always_ff @(posedge clk) begin
    start_signal <= 1'b0;
    spi_start    <= 1'b0;
    fifo_wr      <= 1'b0;
    if (rst) begin
      state     <= S_IDLE;
      remaining <= '0;
      timer     <= '0;
      byte_cnt  <= '0;
      reg_sel   <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          // fifo_full lags a write by one cycle
          if (remaining != 7'd0 && !abort && !fifo_full && !fifo_wr) begin
            start_signal <= 1'b1;
            remaining    <= remaining - 7'd1;
            timer        <= '0;
            state        <= S_WAIT_INT;
          end
        end
        S_WAIT_INT: begin
          if (!tdc_intb) begin
            byte_cnt <= '0;
            reg_sel  <= 1'b0;
            state    <= S_SPI_SEND;
          end else if (timer == TMR_W'(`INTB_TIMEOUT - 1)) begin
            rec_data <= {TDC_TIME_TIMEOUT, TDC_TIME_TIMEOUT};
            fifo_wr  <= 1'b1;
            state    <= S_IDLE;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        S_SPI_SEND: if (!spi_busy) begin
          spi_start   <= 1'b1;
          spi_last    <= (byte_cnt == LAST_BYTE);
          spi_data_in <= (byte_cnt == 2'd0) ?
                         {2'b00, reg_sel ? TDC_REG_TIME2 : TDC_REG_TIME1} : 8'h00;
          state       <= S_SPI_WAIT;
        end
        S_SPI_WAIT: if (spi_new_data) begin
          if (byte_cnt != 2'd0) rec_data <= {rec_data[$bits(rec_data)-9:0], spi_data_out};
          if (byte_cnt == LAST_BYTE) begin
            byte_cnt <= '0;
            if (reg_sel) begin
              fifo_wr <= 1'b1;   // rec_data now {time1, time2}
              state   <= S_IDLE;
            end else begin
              reg_sel <= 1'b1;
              state   <= S_SPI_SEND;
            end
          end else begin
            byte_cnt <= byte_cnt + 2'd1;
            state    <= S_SPI_SEND;
          end
        end
        S_CLOSE: if (!spi_busy) begin
          if (cs_open) begin
            spi_start   <= 1'b1;
            spi_last    <= 1'b1;
            spi_data_in <= 8'h00;
            state       <= S_CLOSE_WAIT;
          end else begin
            state <= S_IDLE;
          end
        end
        S_CLOSE_WAIT: if (spi_new_data) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase

      if (abort && meas_busy) begin
        state     <= S_CLOSE;
        spi_start <= 1'b0;
        fifo_wr   <= 1'b0;   // partial record is dropped
      end
      if (abort || pause) remaining <= '0;  // pause lets the current one finish
      else if (play) remaining <= burst_len;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) cs_open <= 1'b0;
    else if (spi_start) cs_open <= !spi_last;
  end

  always_ff @(posedge clk) begin
    if (rst || !tdc_enable) begin
      ref_cnt   <= '0;
      ref_clock <= 1'b0;
    end else if (ref_cnt == REF_W'(`REF_CLK_DIV - 1)) begin
      ref_cnt   <= '0;
      ref_clock <= ~ref_clock;
    end else begin
      ref_cnt <= ref_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/result_fifo_serializer.sv
`timescale 1ns/1ps
`include "tdc_macros.svh"
`default_nettype none

module result_fifo_serializer (
  input  wire        clk,
  input  wire        rst,
  input  wire        flush,
  input  wire        fifo_wr,
  input  wire  [2*tdc_pkg::TDC_TIME_W-1:0] rec_data,
  output logic       fifo_full,
  output logic       fifo_empty,
  output logic [7:0] tx_data,
  output logic       new_tx_data,
  input  wire        tx_busy
);
  localparam int AW    = `FIFO_ADDR_W;
  localparam int DEPTH = 1 << AW;
  localparam int REC_W = $bits(rec_data);
  localparam logic [2:0] LAST_STEP = 3'd6;   // sync byte plus six data bytes

  logic [REC_W-1:0] mem [DEPTH];
  logic [AW:0]      wr_ptr;     // extra bit tells full from empty
  logic [AW:0]      rd_ptr;
  logic [REC_W-1:0] out_rec;
  logic             active;     // record popped, bytes left to send
  logic [2:0]       step;

  assign fifo_empty = (wr_ptr == rd_ptr);
  assign fifo_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  always_ff @(posedge clk) begin
    if (fifo_wr && !fifo_full) mem[wr_ptr[AW-1:0]] <= rec_data;
  end

  always_ff @(posedge clk) begin
    new_tx_data <= 1'b0;
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      active <= 1'b0;
      step   <= '0;
    end else begin
      if (fifo_wr && !fifo_full) wr_ptr <= wr_ptr + 1'b1;

      if (!active) begin
        if (!fifo_empty) begin
          out_rec <= mem[rd_ptr[AW-1:0]];
          rd_ptr  <= rd_ptr + 1'b1;
          active  <= 1'b1;
          step    <= '0;
        end
      end else if (!tx_busy && !new_tx_data) begin
        // skip the cycle after a strobe so tx_busy can rise
        new_tx_data <= 1'b1;
        if (step == 3'd0) begin
          tx_data <= `REC_SYNC;
        end else begin
          tx_data <= out_rec[REC_W-1 -: 8];   // msb first
          out_rec <= {out_rec[REC_W-9:0], 8'h00};
        end
        if (step == LAST_STEP) active <= 1'b0;
        else step <= step + 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/tdc_readout_top.sv
`timescale 1ns/1ps
`include "tdc_macros.svh"
`default_nettype none

module tdc_readout_top (
  input  wire       clk,
  input  wire       rst,
  input  wire [7:0] rx_data,
  input  wire       new_rx_data,
  output wire [7:0] tx_data,
  output wire       new_tx_data,
  input  wire       tx_busy,
  output wire       tdc_sck,
  output wire       tdc_mosi,
  input  wire       tdc_miso,
  output wire       tdc_cs_n,
  output wire       tdc_enable,
  output wire       tdc_ref_clock,
  output wire       tdc_start_signal,
  input  wire       tdc_intb,
  output wire       fifo_full,
  output wire       fifo_empty
);
  import tdc_pkg::*;

  logic                    play;
  logic                    pause;
  logic                    soft_reset;   // also flushes the result FIFO
  logic [6:0]              burst_len;
  logic                    spi_start;
  logic                    spi_last;
  logic [7:0]              spi_data_in;
  logic [7:0]              spi_data_out;
  logic                    spi_busy;
  logic                    spi_new_data;
  logic                    fifo_wr;
  logic [2*TDC_TIME_W-1:0] rec_data;

  host_cmd_decode u_decode (
    .clk(clk), .rst(rst),
    .rx_data(rx_data), .new_rx_data(new_rx_data),
    .tdc_enable(tdc_enable), .play(play), .pause(pause),
    .soft_reset(soft_reset), .burst_len(burst_len)
  );

  tdc_measure_ctrl u_measure (
    .clk(clk), .rst(rst),
    .tdc_enable(tdc_enable), .play(play), .pause(pause),
    .soft_reset(soft_reset), .burst_len(burst_len), .fifo_full(fifo_full),
    .start_signal(tdc_start_signal), .tdc_intb(tdc_intb), .ref_clock(tdc_ref_clock),
    .spi_start(spi_start), .spi_last(spi_last), .spi_data_in(spi_data_in),
    .spi_data_out(spi_data_out), .spi_busy(spi_busy), .spi_new_data(spi_new_data),
    .fifo_wr(fifo_wr), .rec_data(rec_data)
  );

  tdc_spi_master #(.CLK_DIV(`TDC_SPI_CLK_DIV)) u_spi (
    .clk(clk), .rst(rst),
    .start(spi_start), .last(spi_last), .data_in(spi_data_in),
    .data_out(spi_data_out), .busy(spi_busy), .new_data(spi_new_data),
    .sck(tdc_sck), .mosi(tdc_mosi), .miso(tdc_miso), .cs_n(tdc_cs_n)
  );

  result_fifo_serializer u_result (
    .clk(clk), .rst(rst), .flush(soft_reset),
    .fifo_wr(fifo_wr), .rec_data(rec_data),
    .fifo_full(fifo_full), .fifo_empty(fifo_empty),
    .tx_data(tx_data), .new_tx_data(new_tx_data), .tx_busy(tx_busy)
  );

endmodule

`default_nettype wire

// File: tb/tdc_spi_model.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_spi_model (
  input  wire  clk,
  input  wire  start_signal,
  output logic intb,
  input  wire  sck,
  input  wire  mosi,
  output logic miso,
  input  wire  cs_n
);
  import tdc_pkg::*;

  logic [15:0] next_n = '0;        // index handed to the next answered start
  logic [15:0] cur_n = '0;
  logic        ignore_next = 1'b0; // set by the testbench to miss one start
  logic [7:0]  cmd = '0;
  logic [23:0] time_val;
  integer      bit_cnt = 0;
  integer      seed = 32'he86c_00f3;
  integer      delay;

  initial begin
    intb = 1'b1;
    miso = 1'b0;
  end

  // measurement, intb falls after a random delay
  always @(posedge clk) begin
    if (start_signal) begin
      if (ignore_next) begin
        ignore_next = 1'b0;
      end else begin
        cur_n  = next_n;
        next_n = next_n + 16'd1;
        delay  = 4 + ($unsigned($random(seed)) % 32);
        repeat (delay) @(negedge clk);
        intb = 1'b0;
      end
    end
  end

  always @(negedge cs_n) begin
    intb    = 1'b1;   // interrupt cleared by the read
    bit_cnt = 0;
    miso    = 1'b0;
  end

  always @(posedge sck) begin
    if (!cs_n) begin
      if (bit_cnt < 8) cmd = {cmd[6:0], mosi};   // command byte only
      bit_cnt = bit_cnt + 1;
    end
  end

  // command byte first, then 24 data bits msb first
  always @(negedge sck) begin
    if (!cs_n) begin
      time_val = (cmd[5:0] == TDC_REG_TIME2) ? {8'h20, cur_n} : {8'h10, cur_n};
      if (bit_cnt >= 8 && bit_cnt < 32) miso = time_val[31 - bit_cnt];
      else miso = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: tb/tdc_readout_props.sv
`timescale 1ns/1ps
`include "tdc_macros.svh"
`default_nettype none

module tdc_readout_props (
  input wire clk,
  input wire rst,
  input wire sck,
  input wire cs_n,
  input wire fifo_wr,
  input wire fifo_full,
  input wire new_tx_data,
  input wire tx_busy
);
  localparam int HALF = `TDC_SPI_CLK_DIV;

  sck_idle_low: assert property (@(posedge clk) disable iff (rst) cs_n |-> !sck)
    else $error("sck high while cs_n is high");

  // sck holds each level for more than one clock
  sck_half_period: assert property (@(posedge clk) disable iff (rst)
    (HALF > 1 && $changed(sck)) |=> $stable(sck))
    else $error("sck half period shorter than the divider");

  no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    fifo_wr |-> !fifo_full)
    else $error("fifo write while full");

  // strobe decided on the previous edge
  no_strobe_when_busy: assert property (@(posedge clk) disable iff (rst)
    new_tx_data |-> !$past(tx_busy))
    else $error("tx strobe while tx_busy was high");

endmodule

bind tdc_spi_master tdc_readout_props spi_props (
  .clk(clk), .rst(rst), .sck(sck), .cs_n(cs_n),
  .fifo_wr(1'b0), .fifo_full(1'b0), .new_tx_data(1'b0), .tx_busy(1'b0)
);

bind result_fifo_serializer tdc_readout_props result_props (
  .clk(clk), .rst(rst), .sck(1'b0), .cs_n(1'b1),
  .fifo_wr(fifo_wr), .fifo_full(fifo_full), .new_tx_data(new_tx_data), .tx_busy(tx_busy)
);

`default_nettype wire

// File: tb/tdc_readout_tb.sv
`timescale 1ns/1ps
`include "tdc_macros.svh"
`default_nettype none

module tdc_readout_tb;
  import host_pkg::*;

  logic       clk;
  logic       rst;
  logic [7:0] rx_data;
  logic       new_rx_data;
  logic       tx_busy = 1'b0;
  wire  [7:0] tx_data;
  wire        new_tx_data;
  wire        tdc_sck;
  wire        tdc_mosi;
  wire        tdc_miso;
  wire        tdc_cs_n;
  wire        tdc_enable;
  wire        tdc_ref_clock;
  wire        tdc_start_signal;
  wire        tdc_intb;
  wire        fifo_full;
  wire        fifo_empty;

  logic [7:0] exp_q[$];   // bytes the host should see, in order
  logic [7:0] rx_q[$];
  logic [7:0] got_byte;
  int         rx_count = 0;
  int         start_cnt = 0;
  int         cs_rises = 0;
  int         busy_cnt = 0;
  int         tx_hold = 3;
  logic       hold_busy = 1'b0;
  logic       cs_prev = 1'b1;
  int         base;
  int         toggles;

  tdc_readout_top uut (
    .clk(clk), .rst(rst), .rx_data(rx_data), .new_rx_data(new_rx_data),
    .tx_data(tx_data), .new_tx_data(new_tx_data), .tx_busy(tx_busy),
    .tdc_sck(tdc_sck), .tdc_mosi(tdc_mosi), .tdc_miso(tdc_miso), .tdc_cs_n(tdc_cs_n),
    .tdc_enable(tdc_enable), .tdc_ref_clock(tdc_ref_clock),
    .tdc_start_signal(tdc_start_signal), .tdc_intb(tdc_intb),
    .fifo_full(fifo_full), .fifo_empty(fifo_empty)
  );

  tdc_spi_model tdc_chip (
    .clk(clk), .start_signal(tdc_start_signal), .intb(tdc_intb),
    .sck(tdc_sck), .mosi(tdc_mosi), .miso(tdc_miso), .cs_n(tdc_cs_n)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // sync byte, then time1 and time2 msb first
  function automatic logic [55:0] expected_frame(input logic [15:0] n, input logic timed_out);
    logic [23:0] t1;
    logic [23:0] t2;
    t1 = timed_out ? 24'hFF_FFFF : {8'h10, n};
    t2 = timed_out ? 24'hFF_FFFF : {8'h20, n};
    return {`REC_SYNC, t1, t2};
  endfunction

  task automatic push_frame(input logic [55:0] f);
    for (int i = 6; i >= 0; i--) exp_q.push_back(f[i*8 +: 8]);
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERR %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp));
  endtask

  task automatic send_byte(input logic [7:0] b);
    @(negedge clk);
    rx_data     = b;
    new_rx_data = 1'b1;
    @(negedge clk);
    new_rx_data = 1'b0;
  endtask

  task automatic wait_bytes(input int total, input int limit);
    int i;
    for (i = 0; i < limit && rx_count < total; i++) @(negedge clk);
    if (rx_count < total)
      abort_run($sformatf("timed out waiting for %0d tx bytes, only %0d came", total, rx_count));
  endtask

  task automatic wait_fifo_full(input int limit);
    int i;
    for (i = 0; i < limit && !fifo_full; i++) @(negedge clk);
    if (!fifo_full) abort_run("timed out waiting for the result FIFO to fill");
  endtask

  task automatic wait_cs_rises(input int total, input int limit);
    int i;
    for (i = 0; i < limit && cs_rises < total; i++) @(negedge clk);
    if (cs_rises < total) abort_run("timed out waiting for SPI register reads");
  endtask

  task automatic settle(input int cycles);
    repeat (cycles) @(negedge clk);
  endtask

  task automatic count_toggles(input int cycles, output int n);
    logic prev;
    n    = 0;
    prev = tdc_ref_clock;
    repeat (cycles) begin
      @(negedge clk);
      if (tdc_ref_clock != prev) n++;
      prev = tdc_ref_clock;
    end
  endtask

  // every start gets its expected frame, timed out if the chip misses it
  always @(negedge clk) begin
    if (!rst && tdc_start_signal) begin
      start_cnt++;
      push_frame(expected_frame(tdc_chip.next_n, tdc_chip.ignore_next));
    end
    if (!rst && tdc_cs_n && !cs_prev) cs_rises++;
    cs_prev = tdc_cs_n;
  end

  // host transmitter, busy for tx_hold cycles after each strobe
  always @(negedge clk) begin
    if (busy_cnt > 0) busy_cnt--;
    if (!rst && new_tx_data) begin
      rx_q.push_back(tx_data);
      rx_count++;
      busy_cnt = tx_hold;
    end
    tx_busy = hold_busy || (busy_cnt > 0);
  end

  always @(negedge clk) begin
    while (rx_q.size() > 0) begin
      got_byte = rx_q.pop_front();
      if (exp_q.size() == 0) abort_run("the DUT sent a byte that no measurement explains");
      else check_value("tx byte", got_byte, exp_q.pop_front());
    end
  end

  initial begin
    #4_000_000;
    abort_run("simulation ran past its time limit");
  end

  initial begin
    rst         = 1'b1;
    rx_data     = 8'h00;
    new_rx_data = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // burst of three
    send_byte({1'b0, OP_ENABLE, 4'h0});
    check_value("tdc_enable after enable", tdc_enable, 1);
    send_byte({1'b1, 7'd3});
    send_byte({1'b0, OP_PLAY, 4'h0});
    wait_bytes(21, 20000);
    settle(3000);
    check_value("bytes after burst of 3", rx_count, 21);
    check_value("starts after burst of 3", start_cnt, 3);

    // one missed interrupt, host never busy
    tx_hold = 0;
    tdc_chip.ignore_next = 1'b1;
    send_byte({1'b1, 7'd2});
    send_byte({1'b0, OP_PLAY, 4'h0});
    wait_bytes(35, 20000);
    settle(3000);
    check_value("bytes after timeout burst", rx_count, 35);
    tx_hold = 3;

    // gating by enable
    send_byte({1'b0, OP_DISABLE, 4'h0});
    check_value("tdc_enable after disable", tdc_enable, 0);
    send_byte({1'b0, OP_PLAY, 4'h0});
    count_toggles(1500, toggles);
    check_value("ref clock toggles while disabled", toggles, 0);
    check_value("bytes after play while disabled", rx_count, 35);
    send_byte({1'b0, OP_ENABLE, 4'h0});
    count_toggles(40, toggles);
    check_value("ref clock running when enabled", toggles >= 4, 1);
    send_byte({1'b0, OP_DISABLE, 4'h0});
    settle(2);
    count_toggles(40, toggles);
    check_value("ref clock toggles after disable", toggles, 0);
    check_value("ref clock level after disable", tdc_ref_clock, 0);
    send_byte({1'b0, OP_ENABLE, 4'h0});

    // back-pressure through a burst of 10
    hold_busy = 1'b1;
    send_byte({1'b1, 7'd10});
    send_byte({1'b0, OP_PLAY, 4'h0});
    wait_fifo_full(30000);
    hold_busy = 1'b0;
    wait_bytes(105, 40000);
    settle(3000);
    check_value("bytes after back-pressure burst", rx_count, 105);

    // pause in a long burst
    send_byte({1'b1, 7'd20});
    send_byte({1'b0, OP_PLAY, 4'h0});
    wait_bytes(119, 20000);
    send_byte({1'b0, OP_PAUSE, 4'h0});
    base = start_cnt;
    settle(4000);
    check_value("starts after pause at most one", start_cnt - base <= 1, 1);
    check_value("frames left after pause", exp_q.size(), 0);

    // soft reset with records queued
    hold_busy = 1'b1;
    send_byte({1'b1, 7'd4});
    base = cs_rises;
    send_byte({1'b0, OP_PLAY, 4'h0});
    wait_cs_rises(base + 8, 20000);
    settle(10);
    check_value("fifo_empty with records queued", fifo_empty, 0);
    base = rx_count;
    send_byte({1'b0, OP_SOFT_RESET, 4'h0});
    settle(2);   // flush lands one cycle after the decoded pulse
    check_value("fifo_empty after soft reset", fifo_empty, 1);
    exp_q.delete();   // flushed records never leave
    hold_busy = 1'b0;
    settle(1500);
    check_value("bytes after soft reset", rx_count, base);
    base = start_cnt;
    send_byte({1'b0, OP_PLAY, 4'h0});
    wait_bytes(rx_count + 7, 20000);
    settle(3000);
    check_value("starts after play with reset burst length", start_cnt - base, 1);

    if (exp_q.size() == 0 && rx_q.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run("expected bytes never arrived from the DUT");
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+src
src/host_pkg.sv
src/tdc_pkg.sv
src/host_cmd_decode.sv
src/tdc_spi_master.sv
src/tdc_measure_ctrl.sv
src/result_fifo_serializer.sv
src/tdc_readout_top.sv
tb/tdc_spi_model.sv
tb/tdc_readout_props.sv
tb/tdc_readout_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tdc_readout_tb
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
